// File: ibuf.f
+incdir+include
hdl/xgmiiPkg.sv
hdl/flPkg.sv
hdl/ibufFifo.sv
hdl/xgmiiRxDecoder.sv
hdl/ibufFrameCheck.sv
hdl/flTxMarshal.sv
hdl/ibufMi32Regs.sv
hdl/ibufTop.sv
dv/ibufTb.sv

// File: dv/ibufStimulus.txt
# W addr data | X data ctrl count | B data sof rem count | T len flags | R addr value
# P mode | E test; hex except counts, sof, rem and mode; X data counts up while ctrl is 0
X d5555555555555fb 01 1
X 1100000000000000 00 8
X 07070707070707fd ff 1
B 1100000000000000 1 7 8
T 0040 0
E basic
X d5555555555555fb 01 1
X 2200000000000000 00 9
X 07070707070707fd ff 1
B 2200000000000000 1 7 9
T 0048 0
X d5555555555555fb 01 1
X 3300000000000000 00 8
X 07070707fd332211 f8 1
B 3300000000000000 1 7 8
B 07070707fd332211 0 2 1
T 0043 0
E lanes
W 04 48
X d5555555555555fb 01 1
X 4400000000000000 00 4
X 07070707070707fd ff 1
B 4400000000000000 1 7 4
T 0020 4
X d5555555555555fb 01 1
X 5500000000000000 00 3
X 55000000000000fe 01 1
X 5500000000000010 00 4
X 07070707070707fd ff 1
B 5500000000000000 1 7 3
B 55000000000000fe 0 7 1
B 5500000000000010 0 7 4
T 0040 8
X d5555555555555fb 01 1
X 6600000000000000 00 10
X 07070707070707fd ff 1
B 6600000000000000 1 7 10
T 0050 2
E errors
W 04 5f2
W 00 0
X d5555555555555fb 01 1
X 7700000000000000 00 8
X 07070707070707fd ff 1
W 00 1
X d5555555555555fb 01 1
X 7800000000000000 00 8
X 07070707070707fd ff 1
B 7800000000000000 1 7 8
T 0040 0
E enable
P 1
X d5555555555555fb 01 1
X 8800000000000000 00 8
X 07070707070707fd ff 1
B 8800000000000000 1 7 8
T 0040 0
E random
P 2
X d5555555555555fb 01 1
X 9900000000000000 00 8
X 07070707070707fd ff 1
B 9900000000000000 1 7 8
T 0040 0
X d5555555555555fb 01 1
X aa00000000000000 00 20
X 07070707070707fd ff 1
X d5555555555555fb 01 1
X bb00000000000000 00 8
X 07070707070707fd ff 1
X d5555555555555fb 01 1
X cc00000000000000 00 8
X 07070707070707fd ff 1
P 3
E stall
R 0c 6
R 10 3
R 14 0
E counters

// File: dv/ibufTb.sv
// Testbench for the receive input buffer: file-driven XGMII and MI32, FrameLink checks
`include "ibuf_cfg.svh"

module ibufTb;

  localparam logic [63:0] idleData = 64'h0707_0707_0707_0707;

  logic               xgmiiClk = 1'b0;
  logic               rst;
  xgmiiPkg::xgmiiWord xgmiiIn;
  flPkg::mi32Req      mi32In;
  flPkg::mi32Rsp      mi32Out;
  flPkg::flBeat       flOut;
  logic               flSrcRdy;
  logic               flDstRdy;

  flPkg::flBeat expQ[$];
  string        lines[$];
  integer       seed = 32'h9744_46bc;
  int           stallMode = 0;
  // Beats past the queue are tolerated once the long stall begins
  logic         loose = 1'b0;
  int           looseSent = 0;
  int           looseSeen = 0;
  int           looseGood = 0;
  int           looseBad = 0;
  int           errors = 0;
  int           testErrStart = 0;
  int           testsOk = 0;
  int           testsBad = 0;
  int           cycles = 0;
  int           cycleLimit = 0;

  ibufTop i_dut (
    .xgmiiClk(xgmiiClk), .rst(rst), .xgmiiIn(xgmiiIn), .mi32In(mi32In),
    .mi32Out(mi32Out), .flOut(flOut), .flSrcRdy(flSrcRdy), .flDstRdy(flDstRdy)
  );

  always #4 xgmiiClk = ~xgmiiClk;

  // Sink ready pattern, changed just after the edge
  always @(posedge xgmiiClk) begin
    #1;
    case (stallMode)
      1:       flDstRdy = $random(seed) & 1;
      2:       flDstRdy = 1'b0;
      default: flDstRdy = 1'b1;
    endcase
  end

  // Run limit
  always @(posedge xgmiiClk) begin
    cycles++;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("timeout: expected FrameLink beats never arrived, %0d still queued",
               expQ.size());
      $display("Test failed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // FrameLink monitor, sampled mid-cycle
  // ---------------------------------------------------------------------------
  always @(negedge xgmiiClk) begin : monitor
    flPkg::flBeat exp;
    if (!rst && flSrcRdy && flDstRdy) begin
      if (loose && flOut.trailer) begin
        looseSeen++;
      end
      if (expQ.size() > 0) begin
        exp = expQ.pop_front();
        assert (flOut === exp) else begin
          $display("mismatch at %0t: flOut expected %h got %h", $time, exp, flOut);
          errors++;
        end
      end else if (loose) begin
        // Unchecked frame, classified by its trailer flags
        if (flOut.trailer && flOut.data[3:0] == 4'd0) begin
          looseGood++;
        end else if (flOut.trailer) begin
          looseBad++;
        end
      end else begin
        assert (1'b0) else begin
          $display("unexpected beat on flOut at %0t with nothing expected", $time);
          errors++;
        end
      end
    end
  end

  function automatic flPkg::flBeat dataExp(logic [63:0] d, logic sof, logic [2:0] rem);
    flPkg::flBeat b;
    b.data    = d;
    b.sof     = sof;
    b.eof     = 1'b0;
    b.rem     = rem;
    b.trailer = 1'b0;
    return b;
  endfunction

  // Status sits in the low bits as {len, flags}
  function automatic flPkg::flBeat trailerExp(logic [15:0] len, logic [3:0] flags);
    flPkg::flBeat b;
    b.data    = {44'd0, len, flags};
    b.sof     = 1'b0;
    b.eof     = 1'b1;
    b.rem     = 3'd7;
    b.trailer = 1'b1;
    return b;
  endfunction

  task automatic driveWords(logic [63:0] d, logic [7:0] c, int n);
    for (int i = 0; i < n; i++) begin
      @(posedge xgmiiClk);
      #1;
      xgmiiIn.data = d;
      xgmiiIn.ctrl = c;
      if (loose && c[0] && d[7:0] == 8'hFB) begin
        looseSent++;
      end
      if (c == 8'h00) begin
        d = d + 64'd1;
      end
    end
  endtask

  // Beats of one run, rem 7 except on the last
  task automatic queueBeats(logic [63:0] d, logic sof, logic [2:0] rem, int n);
    for (int i = 0; i < n; i++) begin
      expQ.push_back(dataExp(d + 64'(i), sof && i == 0, (i == n - 1) ? rem : 3'd7));
    end
  endtask

  task automatic regWrite(logic [31:0] addr, logic [31:0] val);
    @(posedge xgmiiClk);
    #1;
    xgmiiIn = '{data: idleData, ctrl: 8'hFF};
    mi32In.addr = addr;
    mi32In.dwr  = val;
    mi32In.wr   = 1'b1;
    @(posedge xgmiiClk);
    #1;
    mi32In.wr = 1'b0;
  endtask

  // Output idle: nothing queued and no beat offered for a while
  task automatic waitDrain();
    int quiet;
    quiet = 0;
    @(posedge xgmiiClk);
    #1;
    xgmiiIn = '{data: idleData, ctrl: 8'hFF};
    while (quiet < 16) begin
      @(negedge xgmiiClk);
      if (expQ.size() == 0 && !flSrcRdy) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  task automatic regRead(logic [31:0] addr, logic [31:0] expVal);
    int waited;
    int missing;
    waitDrain();
    @(posedge xgmiiClk);
    #1;
    mi32In.addr = addr;
    mi32In.rd   = 1'b1;
    @(posedge xgmiiClk);
    #1;
    mi32In.rd = 1'b0;
    waited = 0;
    @(negedge xgmiiClk);
    while (!mi32Out.drdy && waited < 4) begin
      waited++;
      @(negedge xgmiiClk);
    end
    assert (mi32Out.drdy) else begin
      $display("MI32 read of %h got no drdy", addr);
      errors++;
    end
    missing = looseSent - looseSeen;
    if (addr == `IBUF_REG_DROP) begin
      // Drop count only bounded below
      assert (mi32Out.drd >= expVal + 32'(missing)) else begin
        $display("mismatch at %0t: DROP expected at least %0d got %0d", $time,
                 expVal + 32'(missing), mi32Out.drd);
        errors++;
      end
    end else begin
      if (addr == `IBUF_REG_GOOD) begin
        expVal = expVal + 32'(looseGood);
      end else if (addr == `IBUF_REG_BAD) begin
        expVal = expVal + 32'(looseBad);
      end
      assert (mi32Out.drd === expVal) else begin
        $display("mismatch at %0t: mi32Out.drd at %h expected %h got %h", $time, addr,
                 expVal, mi32Out.drd);
        errors++;
      end
    end
  endtask

  task automatic finishTest(string name);
    waitDrain();
    if (errors == testErrStart) begin
      $display("test %s: ok", name);
      testsOk++;
    end else begin
      $display("test %s: %0d errors", name, errors - testErrStart);
      testsBad++;
    end
    testErrStart = errors;
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus file reader
  // ---------------------------------------------------------------------------
  initial begin : stimulus
    int          fd;
    int          n;
    int          m;
    int          k;
    string       line;
    string       rest;
    string       name;
    byte         cmd;
    logic [63:0] a;
    logic [63:0] b;
    rst      = 1'b1;
    xgmiiIn  = '{data: idleData, ctrl: 8'hFF};
    mi32In   = '0;
    flDstRdy = 1'b1;
    fd = $fopen("dv/ibufStimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("Test failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) && line.len() > 1 && line.getc(0) != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      cycleLimit = 20 * lines.size() + 200;
      repeat (4) @(posedge xgmiiClk);
      #1;
      rst = 1'b0;
      foreach (lines[i]) begin
        cmd  = lines[i].getc(0);
        rest = lines[i].substr(1, lines[i].len() - 1);
        case (cmd)
          "W": begin
            void'($sscanf(rest, "%h %h", a, b));
            regWrite(a[31:0], b[31:0]);
          end
          "X": begin
            void'($sscanf(rest, "%h %h %d", a, b, n));
            driveWords(a, b[7:0], n);
          end
          "B": begin
            void'($sscanf(rest, "%h %d %d %d", a, m, k, n));
            queueBeats(a, m[0], k[2:0], n);
          end
          "T": begin
            void'($sscanf(rest, "%h %h", a, b));
            expQ.push_back(trailerExp(a[15:0], b[3:0]));
          end
          "R": begin
            void'($sscanf(rest, "%h %h", a, b));
            regRead(a[31:0], b[31:0]);
          end
          "P": begin
            void'($sscanf(rest, "%d", m));
            stallMode = (m == 3) ? 0 : m;
            if (m == 2) begin
              loose = 1'b1;
            end
          end
          "E": begin
            void'($sscanf(rest, "%s", name));
            finishTest(name);
          end
          default: begin
            $display("unknown stimulus command in line %0d", i + 1);
            errors++;
          end
        endcase
      end
      waitDrain();
      $display("summary: %0d tests ok, %0d tests with errors, %0d check errors",
               testsOk, testsBad, errors);
      if (errors == 0 && testsBad == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

// File: hdl/ibufTop.sv
// 10G Ethernet receive input buffer: XGMII in, FrameLink out, MI32 control
`include "ibuf_cfg.svh"

module ibufTop (
  input  logic               xgmiiClk,
  input  logic               rst,
  input  xgmiiPkg::xgmiiWord xgmiiIn,
  input  flPkg::mi32Req      mi32In,
  output flPkg::mi32Rsp      mi32Out,
  output flPkg::flBeat       flOut,
  output logic               flSrcRdy,
  input  logic               flDstRdy
);

  logic                                          enable;
  logic [15:0]                                   mtu;
  logic [15:0]                                   minLen;
  xgmiiPkg::frameBeat                            beat;
  logic                                          beatVld;
  // Checker to FIFOs
  logic                                          dataWr;
  xgmiiPkg::frameBeat                            dataWrBeat;
  logic                                          statWr;
  flPkg::frameStatus                             statWrVal;
  logic [$clog2(`IBUF_DATA_FIFO_DEPTH + 1)-1:0] dataCount;
  logic                                          dataFull;
  logic                                          statFull;
  // FIFOs to marshal
  logic                                          dataRd;
  xgmiiPkg::frameBeat                            dataRdBeat;
  logic                                          dataEmpty;
  logic                                          statRd;
  flPkg::frameStatus                             statRdVal;
  logic                                          statEmpty;
  logic                                          goodPulse;
  logic                                          badPulse;
  logic                                          dropPulse;

  xgmiiRxDecoder i_decoder (
    .xgmiiClk(xgmiiClk), .rst(rst), .enable(enable), .xgmiiIn(xgmiiIn),
    .beat(beat), .beatVld(beatVld)
  );

  ibufFrameCheck i_check (
    .xgmiiClk(xgmiiClk), .rst(rst), .beat(beat), .beatVld(beatVld),
    .mtu(mtu), .minLen(minLen), .dataCount(dataCount), .dataFull(dataFull),
    .statFull(statFull), .dataWr(dataWr), .dataWrBeat(dataWrBeat),
    .statWr(statWr), .statWrVal(statWrVal), .goodPulse(goodPulse),
    .badPulse(badPulse), .dropPulse(dropPulse)
  );

  // Data beats
  ibufFifo #(.payloadT(xgmiiPkg::frameBeat), .depth(`IBUF_DATA_FIFO_DEPTH)) i_dataFifo (
    .xgmiiClk(xgmiiClk), .rst(rst), .wr(dataWr), .wrData(dataWrBeat),
    .rd(dataRd), .rdData(dataRdBeat), .empty(dataEmpty), .full(dataFull),
    .count(dataCount)
  );

  // One status per buffered frame
  ibufFifo #(.payloadT(flPkg::frameStatus), .depth(`IBUF_STAT_FIFO_DEPTH)) i_statFifo (
    .xgmiiClk(xgmiiClk), .rst(rst), .wr(statWr), .wrData(statWrVal),
    .rd(statRd), .rdData(statRdVal), .empty(statEmpty), .full(statFull),
    .count()
  );

  flTxMarshal i_marshal (
    .xgmiiClk(xgmiiClk), .rst(rst), .dataRd(dataRd), .dataBeat(dataRdBeat),
    .dataEmpty(dataEmpty), .statRd(statRd), .stat(statRdVal),
    .statEmpty(statEmpty), .flOut(flOut), .flSrcRdy(flSrcRdy), .flDstRdy(flDstRdy)
  );

  ibufMi32Regs i_regs (
    .xgmiiClk(xgmiiClk), .rst(rst), .mi32In(mi32In), .mi32Out(mi32Out),
    .enable(enable), .mtu(mtu), .minLen(minLen), .goodPulse(goodPulse),
    .badPulse(badPulse), .dropPulse(dropPulse)
  );

endmodule

// File: hdl/ibufMi32Regs.sv
// MI32 register file: enable, length limits and frame counters
`include "ibuf_cfg.svh"

module ibufMi32Regs (
  input  logic          xgmiiClk,
  input  logic          rst,
  input  flPkg::mi32Req mi32In,
  output flPkg::mi32Rsp mi32Out,
  output logic          enable,
  output logic [15:0]   mtu,
  output logic [15:0]   minLen,
  input  logic          goodPulse,
  input  logic          badPulse,
  input  logic          dropPulse
);

  logic [31:0] goodCnt;
  logic [31:0] badCnt;
  logic [31:0] dropCnt;
  logic [31:0] rdVal;
  logic [31:0] rspData;
  logic        rspRdy;

  assign mi32Out = '{drd: rspData, drdy: rspRdy};

  // Read mux, unmapped reads give 0
  always_comb begin
    case (mi32In.addr)
      `IBUF_REG_CTRL: rdVal = {31'd0, enable};
      `IBUF_REG_MTU:  rdVal = {16'd0, mtu};
      `IBUF_REG_MIN:  rdVal = {16'd0, minLen};
      `IBUF_REG_GOOD: rdVal = goodCnt;
      `IBUF_REG_BAD:  rdVal = badCnt;
      `IBUF_REG_DROP: rdVal = dropCnt;
      default:        rdVal = 32'd0;
    endcase
  end

  // -------------------------------------------------------------------------
  // Writable registers and counters
  // -------------------------------------------------------------------------
  always_ff @(posedge xgmiiClk) begin
    if (rst) begin
      enable  <= 1'b1;
      mtu     <= 16'(`IBUF_DEF_MTU);
      minLen  <= 16'(`IBUF_DEF_MIN_LEN);
      goodCnt <= 32'd0;
      badCnt  <= 32'd0;
      dropCnt <= 32'd0;
      rspRdy  <= 1'b0;
    end else begin
      rspRdy <= mi32In.rd;
      if (mi32In.wr) begin
        case (mi32In.addr)
          `IBUF_REG_CTRL: enable <= mi32In.dwr[0];
          `IBUF_REG_MTU:  mtu    <= mi32In.dwr[15:0];
          `IBUF_REG_MIN:  minLen <= mi32In.dwr[15:0];
          default: ;
        endcase
      end
      // Counters are read-only
      if (goodPulse) begin
        goodCnt <= goodCnt + 32'd1;
      end
      if (badPulse) begin
        badCnt <= badCnt + 32'd1;
      end
      if (dropPulse) begin
        dropCnt <= dropCnt + 32'd1;
      end
    end
  end

  // Read data, valid with rspRdy
  always_ff @(posedge xgmiiClk) begin
    if (mi32In.rd) begin
      rspData <= rdVal;
    end
  end

endmodule

// File: hdl/flTxMarshal.sv
// FrameLink transmit marshal: frame data beats followed by a status trailer
module flTxMarshal (
  input  logic                 xgmiiClk,
  input  logic                 rst,
  output logic                 dataRd,
  input  xgmiiPkg::frameBeat   dataBeat,
  input  logic                 dataEmpty,
  output logic                 statRd,
  input  flPkg::frameStatus    stat,
  input  logic                 statEmpty,
  output flPkg::flBeat         flOut,
  output logic                 flSrcRdy,
  input  logic                 flDstRdy
);

  typedef enum logic [1:0] {sIdle, sData, sTrail} stateT;

  stateT state;
  // FIFO read data holds an unsent beat
  logic  dVld;
  logic  firstBeat;
  logic  xfer;
  logic  dataXfer;

  always_comb begin
    flSrcRdy = (state == sData && dVld) || state == sTrail;
    xfer     = flSrcRdy && flDstRdy;
    dataXfer = xfer && state == sData;
    // Prefetch one beat, refill as it leaves
    dataRd   = !dataEmpty && (!dVld || dataXfer);
    // A queued status means the whole frame is in the data FIFO
    statRd   = state == sIdle && !statEmpty;

    flOut.data    = dataBeat.data;
    flOut.sof     = firstBeat;
    flOut.eof     = 1'b0;
    flOut.rem     = dataBeat.rem;
    flOut.trailer = 1'b0;
    if (state == sTrail) begin
      flOut.data    = 64'(stat);
      flOut.sof     = 1'b0;
      flOut.eof     = 1'b1;
      flOut.rem     = 3'd7;
      flOut.trailer = 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // Frame FSM
  // -------------------------------------------------------------------------
  always_ff @(posedge xgmiiClk) begin
    if (rst) begin
      state     <= sIdle;
      dVld      <= 1'b0;
      firstBeat <= 1'b0;
    end else begin
      if (dataRd) begin
        dVld <= 1'b1;
      end else if (dataXfer) begin
        dVld <= 1'b0;
      end
      case (state)
        sIdle: begin
          if (!statEmpty) begin
            state     <= sData;
            firstBeat <= 1'b1;
          end
        end
        sData: begin
          if (dataXfer) begin
            firstBeat <= 1'b0;
            if (dataBeat.eop) begin
              state <= sTrail;
            end
          end
        end
        default: begin
          if (xfer) begin
            state <= sIdle;
          end
        end
      endcase
    end
  end

  // Offered beat stays put until taken
  aHoldUnderStall: assert property (@(posedge xgmiiClk) disable iff (rst)
    flSrcRdy && !flDstRdy |=> flSrcRdy && $stable(flOut));

endmodule

// File: hdl/ibufFrameCheck.sv
// Frame checker: length limits, FIFO writes, truncation and whole-frame drop
`include "ibuf_cfg.svh"

module ibufFrameCheck (
  input  logic                                          xgmiiClk,
  input  logic                                          rst,
  input  xgmiiPkg::frameBeat                            beat,
  input  logic                                          beatVld,
  input  logic [15:0]                                   mtu,
  input  logic [15:0]                                   minLen,
  input  logic [$clog2(`IBUF_DATA_FIFO_DEPTH + 1)-1:0] dataCount,
  input  logic                                          dataFull,
  input  logic                                          statFull,
  output logic                                          dataWr,
  output xgmiiPkg::frameBeat                            dataWrBeat,
  output logic                                          statWr,
  output flPkg::frameStatus                             statWrVal,
  output logic                                          goodPulse,
  output logic                                          badPulse,
  output logic                                          dropPulse
);

  localparam int depth = `IBUF_DATA_FIFO_DEPTH;

  logic                           active;
  logic                           dropping;
  logic                           errAcc;
  logic                           truncAcc;
  logic [15:0]                    len;
  logic [$clog2(depth + 1):0]     level;
  logic                           dropNow;
  logic                           keep;
  logic                           fits;
  logic                           good;
  flPkg::frameStatus              stat;

  always_comb begin
    // Count the write still in flight
    level   = dataCount + dataWr;
    dropNow = beat.sop && (dataFull || level >= depth || statFull);
    keep    = beatVld && (beat.sop ? !dropNow : active);
    // Last slot stays free for the eop
    fits    = beat.eop ? level < depth : level < depth - 1;

    stat.len       = (beat.sop ? 16'd0 : len) +
                     (beat.eop ? 16'(beat.rem) + 16'd1 : 16'd8);
    stat.xgmiiErr  = (beat.sop ? 1'b0 : errAcc) | beat.err;
    stat.truncated = (beat.sop ? 1'b0 : truncAcc) | !fits;
    stat.tooShort  = stat.len < minLen;
    stat.tooLong   = stat.len > mtu;
    good = !(stat.xgmiiErr || stat.tooShort || stat.tooLong || stat.truncated);
  end

  // -------------------------------------------------------------------------
  // Write strobes and frame state
  // -------------------------------------------------------------------------
  always_ff @(posedge xgmiiClk) begin
    if (rst) begin
      active    <= 1'b0;
      dropping  <= 1'b0;
      dataWr    <= 1'b0;
      statWr    <= 1'b0;
      goodPulse <= 1'b0;
      badPulse  <= 1'b0;
      dropPulse <= 1'b0;
    end else begin
      dataWr <= keep && fits;
      // Status slot reserved at sop
      statWr    <= keep && beat.eop;
      goodPulse <= keep && beat.eop && good;
      badPulse  <= keep && beat.eop && !good;
      dropPulse <= beatVld && beat.eop && (beat.sop ? dropNow : dropping);
      if (beatVld) begin
        if (beat.sop) begin
          active   <= !dropNow && !beat.eop;
          dropping <= dropNow && !beat.eop;
        end else if (beat.eop) begin
          active   <= 1'b0;
          dropping <= 1'b0;
        end
      end
    end
  end

  // Accumulators and write payloads
  always_ff @(posedge xgmiiClk) begin
    dataWrBeat <= beat;
    statWrVal  <= stat;
    if (keep) begin
      len      <= stat.len;
      errAcc   <= stat.xgmiiErr;
      truncAcc <= stat.truncated;
    end
  end

  // Status only with the frame's last data beat
  aStatWithEop: assert property (@(posedge xgmiiClk) disable iff (rst)
    statWr |-> dataWr && dataWrBeat.eop);

endmodule

// File: hdl/xgmiiRxDecoder.sv
// XGMII receive decoder: finds frame boundaries and strips the start beat
module xgmiiRxDecoder (
  input  logic               xgmiiClk,
  input  logic               rst,
  input  logic               enable,
  input  xgmiiPkg::xgmiiWord xgmiiIn,
  output xgmiiPkg::frameBeat beat,
  output logic               beatVld
);

  logic               inFrame;
  logic               sopNext;
  logic               holdVld;
  logic               outOpen;
  logic               isStart;
  logic               termHit;
  logic               errHit;
  logic [2:0]         termLane;
  xgmiiPkg::frameBeat hold;
  xgmiiPkg::frameBeat cur;

  // -------------------------------------------------------------------------
  // Control character scan
  // -------------------------------------------------------------------------
  always_comb begin
    termHit  = 1'b0;
    termLane = 3'd0;
    errHit   = 1'b0;
    // Downward scan so the lowest terminate lane wins
    for (int i = 7; i >= 0; i--) begin
      if (xgmiiIn.ctrl[i] && xgmiiIn.data[8*i +: 8] == 8'hFD) begin
        termHit  = 1'b1;
        termLane = 3'(i);
      end
      if (xgmiiIn.ctrl[i] && xgmiiIn.data[8*i +: 8] == 8'hFE) begin
        errHit = 1'b1;
      end
    end
    // Start only in lane 0
    isStart = enable && !inFrame && xgmiiIn.ctrl[0] && xgmiiIn.data[7:0] == 8'hFB;
    cur.data = xgmiiIn.data;
    cur.sop  = sopNext;
    cur.eop  = termHit;
    cur.rem  = termLane - 3'd1;
    cur.err  = errHit;
  end

  // Frame tracking and output strobe
  always_ff @(posedge xgmiiClk) begin
    if (rst) begin
      inFrame <= 1'b0;
      sopNext <= 1'b0;
      holdVld <= 1'b0;
      beatVld <= 1'b0;
    end else begin
      beatVld <= 1'b0;
      if (holdVld && hold.eop) begin
        // Flush of a beat that already carries eop
        beatVld <= 1'b1;
        holdVld <= 1'b0;
      end else if (inFrame) begin
        beatVld <= holdVld;
        if (termHit && termLane == 3'd0) begin
          // Terminate in lane 0 closes the held beat
          holdVld <= 1'b0;
          inFrame <= 1'b0;
        end else begin
          holdVld <= 1'b1;
          sopNext <= 1'b0;
          if (termHit) begin
            inFrame <= 1'b0;
          end
        end
      end
      // Start word itself holds preamble and SFD only
      if (isStart) begin
        inFrame <= 1'b1;
        sopNext <= 1'b1;
      end
    end
  end

  // Beat payload, same branching as above
  always_ff @(posedge xgmiiClk) begin
    if (holdVld && hold.eop) begin
      beat <= hold;
    end else if (inFrame) begin
      beat <= hold;
      if (termHit && termLane == 3'd0) begin
        beat.eop <= 1'b1;
        beat.rem <= 3'd7;
      end else begin
        hold <= cur;
      end
    end
  end

  // Output side frame state
  always_ff @(posedge xgmiiClk) begin
    if (rst) begin
      outOpen <= 1'b0;
    end else if (beatVld) begin
      outOpen <= !beat.eop;
    end
  end

  // Output frames never overlap
  aNoNestedSop: assert property (@(posedge xgmiiClk) disable iff (rst)
    beatVld && beat.sop |-> !outOpen);

endmodule

// File: hdl/ibufFifo.sv
// Synchronous FIFO with registered read data, payload given by type
module ibufFifo #(
  parameter type payloadT = logic [7:0],
  parameter int  depth    = 4
) (
  input  logic                         xgmiiClk,
  input  logic                         rst,
  input  logic                         wr,
  input  payloadT                      wrData,
  input  logic                         rd,
  output payloadT                      rdData,
  output logic                         empty,
  output logic                         full,
  output logic [$clog2(depth + 1)-1:0] count
);

  localparam int ptrW = $clog2(depth);

  payloadT           mem [depth];
  logic [ptrW-1:0]   wrPtr;
  logic [ptrW-1:0]   rdPtr;

  assign empty = count == '0;
  assign full  = count == depth;

  // Pointers and fill level
  always_ff @(posedge xgmiiClk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wr) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (rd) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage, read data holds until next rd
  always_ff @(posedge xgmiiClk) begin
    if (wr) begin
      mem[wrPtr] <= wrData;
    end
    if (rd) begin
      rdData <= mem[rdPtr];
    end
  end

  aNoOverflow: assert property (@(posedge xgmiiClk) disable iff (rst) wr |-> !full);
  aNoUnderflow: assert property (@(posedge xgmiiClk) disable iff (rst) rd |-> !empty);

endmodule

// File: hdl/flPkg.sv
// FrameLink output and MI32 control types for the input buffer
`include "ibuf_cfg.svh"

package flPkg;

  // Per-frame status, good when all four flags are clear
  typedef struct packed {
    logic [15:0] len;
    logic        xgmiiErr;
    logic        tooShort;
    logic        tooLong;
    logic        truncated;
  } frameStatus;

  // FrameLink transmit beat
  typedef struct packed {
    logic [`IBUF_DATA_W-1:0] data;
    logic                    sof;
    logic                    eof;
    logic [2:0]              rem;
    // Status beat, frameStatus in the low data bits
    logic                    trailer;
  } flBeat;

  // MI32 request, wr and rd are one-cycle pulses
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] dwr;
    logic        wr;
    logic        rd;
  } mi32Req;

  // MI32 response, drdy one cycle after rd
  typedef struct packed {
    logic [31:0] drd;
    logic        drdy;
  } mi32Rsp;

endpackage

// File: hdl/xgmiiPkg.sv
// XGMII link-side types: raw SDR receive word and decoded frame beat
`include "ibuf_cfg.svh"

package xgmiiPkg;

  // One SDR XGMII word
  // Lane k is data[8k+7:8k] with control flag ctrl[k]
  typedef struct packed {
    logic [`IBUF_DATA_W-1:0]   data;
    logic [`IBUF_DATA_W/8-1:0] ctrl;
  } xgmiiWord;

  // Decoded frame beat, preamble already stripped
  typedef struct packed {
    logic [`IBUF_DATA_W-1:0] data;
    // First beat of the frame
    logic                    sop;
    // Last beat of the frame
    logic                    eop;
    // Index of the last valid byte, meaningful with eop
    logic [2:0]              rem;
    // Error character seen in this beat
    logic                    err;
  } frameBeat;

endpackage

// File: include/ibuf_cfg.svh
// IBUF configuration: datapath width, buffer depths, MI32 register map and limits
`ifndef IBUF_CFG_SVH
`define IBUF_CFG_SVH

// ---------------------------------------------------------------------------
// Datapath and buffering
// ---------------------------------------------------------------------------
`define IBUF_DATA_W           64
// Beats of frame data
`define IBUF_DATA_FIFO_DEPTH  16
// Whole frames in flight
`define IBUF_STAT_FIFO_DEPTH  4

// Length limits after reset, in bytes with FCS
`define IBUF_DEF_MTU          1522
`define IBUF_DEF_MIN_LEN      64

// ---------------------------------------------------------------------------
// MI32 register map
// ---------------------------------------------------------------------------
`define IBUF_REG_CTRL         32'h0000_0000
`define IBUF_REG_MTU          32'h0000_0004
`define IBUF_REG_MIN          32'h0000_0008
`define IBUF_REG_GOOD         32'h0000_000C
`define IBUF_REG_BAD          32'h0000_0010
`define IBUF_REG_DROP         32'h0000_0014

`endif
